/* Makefile */
SOURCES = $(wildcard verilog/*.sv) test/tb_l2_channels.sv

.PHONY: all run check clean

all: obj_dir/Vtb_l2_channels

obj_dir/Vtb_l2_channels: files.f $(SOURCES)
	verilator --binary --timing --assert --top-module tb_l2_channels -f files.f

sim.log: obj_dir/Vtb_l2_channels
	./obj_dir/Vtb_l2_channels > sim.log 2>&1 || true

run: obj_dir/Vtb_l2_channels
	./obj_dir/Vtb_l2_channels > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation passed" sim.log

check: sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* files.f */
verilog/l2_pkg.sv
verilog/l2_skid_buffer.sv
verilog/l2_coh_ctrl.sv
verilog/l2_channels.sv
test/tb_l2_channels.sv

/* test/tb_l2_channels.sv */
`timescale 1ns/1ps

module tb_l2_channels;

    import l2_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int STALL_CYCLES   = 6;
    // Byte offset bits of one line
    localparam logic [ADDR_BITS-1:0] LINE_MASK = ADDR_BITS'(LINE_BITS / 8 - 1);

    logic                   clk;
    logic                   rst;
    logic                   cpu_req_valid_i;
    logic                   cpu_req_ready_o;
    cpu_msg_t               cpu_req_cpu_msg_i;
    logic [HSIZE_BITS-1:0]  cpu_req_hsize_i;
    logic [HPROT_BITS-1:0]  cpu_req_hprot_i;
    logic [ADDR_BITS-1:0]   cpu_req_addr_i;
    logic [WORD_BITS-1:0]   cpu_req_word_i;
    logic                   fwd_in_valid_i;
    logic                   fwd_in_ready_o;
    coh_msg_t               fwd_in_coh_msg_i;
    logic [ADDR_BITS-1:0]   fwd_in_addr_i;
    logic [REQ_ID_BITS-1:0] fwd_in_req_id_i;
    logic                   rsp_in_valid_i;
    logic                   rsp_in_ready_o;
    coh_msg_t               rsp_in_coh_msg_i;
    logic [ADDR_BITS-1:0]   rsp_in_addr_i;
    logic [LINE_BITS-1:0]   rsp_in_line_i;
    logic                   req_out_valid_o;
    logic                   req_out_ready_i;
    coh_msg_t               req_out_coh_msg_o;
    logic [HPROT_BITS-1:0]  req_out_hprot_o;
    logic [ADDR_BITS-1:0]   req_out_addr_o;
    logic [LINE_BITS-1:0]   req_out_line_o;
    logic                   rsp_out_valid_o;
    logic                   rsp_out_ready_i;
    coh_msg_t               rsp_out_coh_msg_o;
    logic [REQ_ID_BITS-1:0] rsp_out_req_id_o;
    logic                   rsp_out_to_req_o;
    logic [ADDR_BITS-1:0]   rsp_out_addr_o;
    logic [LINE_BITS-1:0]   rsp_out_line_o;
    logic                   rd_rsp_valid_o;
    logic                   rd_rsp_ready_i;
    logic [LINE_BITS-1:0]   rd_rsp_line_o;
    logic [31:0]            lcg_state;

    l2_channels i_dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [LINE_BITS-1:0] rand_line();
        logic [LINE_BITS-1:0] value;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            value[i*WORD_BITS +: WORD_BITS] = next_rand();
        end
        return value;
    endfunction

    function automatic logic [ADDR_BITS-1:0] line_align(input logic [ADDR_BITS-1:0] addr);
        return addr & ~LINE_MASK;
    endfunction

    // Byte offset in the line picks the word slot
    function automatic logic [LINE_BITS-1:0] merge_word(input logic [LINE_BITS-1:0] line,
                                                        input logic [ADDR_BITS-1:0] addr,
                                                        input logic [WORD_BITS-1:0] word);
        logic [LINE_BITS-1:0] result;
        int                   slot;
        slot   = int'(addr[LINE_LSB-1:0]) / (WORD_BITS / 8);
        result = line;
        result[slot*WORD_BITS +: WORD_BITS] = word;
        return result;
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
        abort_run();
    endtask

    task automatic check_msg(input coh_msg_t actual, input coh_msg_t expected,
                             input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %s, expected %s",
                     $time, what, actual.name(), expected.name());
            abort_run();
        end
    endtask

    task automatic check_addr(input logic [ADDR_BITS-1:0] actual,
                              input logic [ADDR_BITS-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_line(input logic [LINE_BITS-1:0] actual,
                              input logic [LINE_BITS-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_id(input logic [REQ_ID_BITS-1:0] actual,
                            input logic [REQ_ID_BITS-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_hprot(input logic [HPROT_BITS-1:0] actual,
                               input logic [HPROT_BITS-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    // All drivers start and end on a falling edge
    task automatic send_cpu(input cpu_msg_t msg, input logic [HPROT_BITS-1:0] hprot,
                            input logic [ADDR_BITS-1:0] addr, input logic [WORD_BITS-1:0] word);
        int waited;
        waited            = 0;
        cpu_req_valid_i   = 1'b1;
        cpu_req_cpu_msg_i = msg;
        cpu_req_hsize_i   = 3'd2;
        cpu_req_hprot_i   = hprot;
        cpu_req_addr_i    = addr;
        cpu_req_word_i    = word;
        while (!cpu_req_ready_o) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) timeout_fail("cpu_req ready");
        end
        @(negedge clk);
        cpu_req_valid_i = 1'b0;
    endtask

    task automatic send_fwd(input logic [ADDR_BITS-1:0] addr,
                            input logic [REQ_ID_BITS-1:0] req_id);
        int waited;
        waited           = 0;
        fwd_in_valid_i   = 1'b1;
        fwd_in_coh_msg_i = FWD_INV;
        fwd_in_addr_i    = addr;
        fwd_in_req_id_i  = req_id;
        while (!fwd_in_ready_o) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) timeout_fail("fwd_in ready");
        end
        @(negedge clk);
        fwd_in_valid_i = 1'b0;
    endtask

    task automatic send_rsp(input logic [ADDR_BITS-1:0] addr, input logic [LINE_BITS-1:0] line);
        int waited;
        waited           = 0;
        rsp_in_valid_i   = 1'b1;
        rsp_in_coh_msg_i = RSP_DATA;
        rsp_in_addr_i    = addr;
        rsp_in_line_i    = line;
        while (!rsp_in_ready_o) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) timeout_fail("rsp_in ready");
        end
        @(negedge clk);
        rsp_in_valid_i = 1'b0;
    endtask

    task automatic take_req(input coh_msg_t msg, input logic [HPROT_BITS-1:0] hprot,
                            input logic [ADDR_BITS-1:0] addr, input logic [LINE_BITS-1:0] line);
        int waited;
        waited = 0;
        while (!req_out_valid_o) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) timeout_fail("req_out valid");
        end
        check_msg(req_out_coh_msg_o, msg, "req_out message");
        check_hprot(req_out_hprot_o, hprot, "req_out hprot");
        check_addr(req_out_addr_o, addr, "req_out address");
        check_line(req_out_line_o, line, "req_out line");
        req_out_ready_i = 1'b1;
        @(negedge clk);
        req_out_ready_i = 1'b0;
    endtask

    task automatic take_rsp_out(input logic [REQ_ID_BITS-1:0] req_id,
                                input logic [ADDR_BITS-1:0] addr);
        int waited;
        waited = 0;
        while (!rsp_out_valid_o) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) timeout_fail("rsp_out valid");
        end
        check_msg(rsp_out_coh_msg_o, RSP_INVACK, "rsp_out message");
        check_id(rsp_out_req_id_o, req_id, "rsp_out req_id");
        check_flag(rsp_out_to_req_o, 1'b1, "rsp_out to_req");
        check_addr(rsp_out_addr_o, addr, "rsp_out address");
        check_line(rsp_out_line_o, '0, "rsp_out line");
        rsp_out_ready_i = 1'b1;
        @(negedge clk);
        rsp_out_ready_i = 1'b0;
    endtask

    task automatic take_rd(input logic [LINE_BITS-1:0] line);
        int waited;
        waited = 0;
        while (!rd_rsp_valid_o) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) timeout_fail("rd_rsp valid");
        end
        check_line(rd_rsp_line_o, line, "rd_rsp line");
        rd_rsp_ready_i = 1'b1;
        @(negedge clk);
        rd_rsp_ready_i = 1'b0;
    endtask

    // Consumer stays stalled, the item must not move
    task automatic hold_rd(input logic [LINE_BITS-1:0] line);
        int waited;
        waited = 0;
        while (!rd_rsp_valid_o) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) timeout_fail("rd_rsp valid");
        end
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            check_flag(rd_rsp_valid_o, 1'b1, "stalled rd_rsp valid");
            check_line(rd_rsp_line_o, line, "stalled rd_rsp line");
        end
    endtask

    task automatic hold_req(input coh_msg_t msg, input logic [ADDR_BITS-1:0] addr,
                            input logic [LINE_BITS-1:0] line);
        int waited;
        waited = 0;
        while (!req_out_valid_o) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) timeout_fail("req_out valid");
        end
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            check_flag(req_out_valid_o, 1'b1, "stalled req_out valid");
            check_msg(req_out_coh_msg_o, msg, "stalled req_out message");
            check_addr(req_out_addr_o, addr, "stalled req_out address");
            check_line(req_out_line_o, line, "stalled req_out line");
        end
    endtask

    task automatic idle_after_reset();
        check_flag(req_out_valid_o, 1'b0, "req_out valid after reset");
        check_flag(rsp_out_valid_o, 1'b0, "rsp_out valid after reset");
        check_flag(rd_rsp_valid_o, 1'b0, "rd_rsp valid after reset");
        check_flag(cpu_req_ready_o, 1'b1, "cpu_req ready after reset");
        check_flag(fwd_in_ready_o, 1'b1, "fwd_in ready after reset");
        check_flag(rsp_in_ready_o, 1'b1, "rsp_in ready after reset");
    endtask

    task automatic read_miss();
        logic [ADDR_BITS-1:0] addr;
        logic [LINE_BITS-1:0] line;
        logic [31:0]          r;
        addr = next_rand();
        r    = next_rand();
        line = rand_line();
        send_cpu(CPU_READ, r[1:0], addr, r);
        take_req(REQ_GETS, r[1:0], line_align(addr), '0);
        send_rsp(line_align(addr), line);
        take_rd(line);
    endtask

    task automatic write_miss();
        logic [ADDR_BITS-1:0] addr;
        logic [WORD_BITS-1:0] word;
        logic [LINE_BITS-1:0] line;
        logic [31:0]          r;
        addr = next_rand();
        word = next_rand();
        r    = next_rand();
        line = rand_line();
        send_cpu(CPU_WRITE, r[1:0], addr, word);
        take_req(REQ_GETM, r[1:0], line_align(addr), '0);
        send_rsp(line_align(addr), line);
        take_req(REQ_PUTM, r[1:0], line_align(addr), merge_word(line, addr, word));
    endtask

    task automatic invalidation();
        logic [ADDR_BITS-1:0] inv_addr;
        logic [ADDR_BITS-1:0] miss_addr;
        logic [LINE_BITS-1:0] line;
        logic [31:0]          r;
        inv_addr = next_rand();
        r        = next_rand();
        send_fwd(inv_addr, r[REQ_ID_BITS-1:0]);
        take_rsp_out(r[REQ_ID_BITS-1:0], inv_addr);
        // Same again while a read miss waits for its data
        miss_addr = next_rand();
        line      = rand_line();
        send_cpu(CPU_READ, 2'd0, miss_addr, 32'd0);
        take_req(REQ_GETS, 2'd0, line_align(miss_addr), '0);
        inv_addr = next_rand();
        r        = next_rand();
        send_fwd(inv_addr, r[REQ_ID_BITS-1:0]);
        take_rsp_out(r[REQ_ID_BITS-1:0], inv_addr);
        send_rsp(line_align(miss_addr), line);
        take_rd(line);
    endtask

    task automatic back_pressure();
        logic [ADDR_BITS-1:0] addr_a;
        logic [ADDR_BITS-1:0] addr_b;
        logic [WORD_BITS-1:0] word_b;
        logic [LINE_BITS-1:0] line_a;
        logic [LINE_BITS-1:0] line_b;
        addr_a = next_rand();
        addr_b = next_rand();
        word_b = next_rand();
        line_a = rand_line();
        line_b = rand_line();
        send_cpu(CPU_READ, 2'd1, addr_a, 32'd0);
        take_req(REQ_GETS, 2'd1, line_align(addr_a), '0);
        send_rsp(line_align(addr_a), line_a);
        hold_rd(line_a);
        take_rd(line_a);
        send_cpu(CPU_WRITE, 2'd3, addr_b, word_b);
        take_req(REQ_GETM, 2'd3, line_align(addr_b), '0);
        send_rsp(line_align(addr_b), line_b);
        hold_req(REQ_PUTM, line_align(addr_b), merge_word(line_b, addr_b, word_b));
        take_req(REQ_PUTM, 2'd3, line_align(addr_b), merge_word(line_b, addr_b, word_b));
        // Second request sits in the cpu_req buffer until the first miss ends
        addr_a = next_rand();
        addr_b = next_rand();
        word_b = next_rand();
        line_a = rand_line();
        line_b = rand_line();
        send_cpu(CPU_READ, 2'd2, addr_a, 32'd0);
        send_cpu(CPU_WRITE, 2'd1, addr_b, word_b);
        take_req(REQ_GETS, 2'd2, line_align(addr_a), '0);
        send_rsp(line_align(addr_a), line_a);
        take_rd(line_a);
        take_req(REQ_GETM, 2'd1, line_align(addr_b), '0);
        send_rsp(line_align(addr_b), line_b);
        take_req(REQ_PUTM, 2'd1, line_align(addr_b), merge_word(line_b, addr_b, word_b));
    endtask

    initial begin
        lcg_state         = 32'hc9be;
        rst               = 1'b0;
        cpu_req_valid_i   = 1'b0;
        cpu_req_cpu_msg_i = CPU_READ;
        cpu_req_hsize_i   = '0;
        cpu_req_hprot_i   = '0;
        cpu_req_addr_i    = '0;
        cpu_req_word_i    = '0;
        fwd_in_valid_i    = 1'b0;
        fwd_in_coh_msg_i  = FWD_INV;
        fwd_in_addr_i     = '0;
        fwd_in_req_id_i   = '0;
        rsp_in_valid_i    = 1'b0;
        rsp_in_coh_msg_i  = RSP_DATA;
        rsp_in_addr_i     = '0;
        rsp_in_line_i     = '0;
        req_out_ready_i   = 1'b0;
        rsp_out_ready_i   = 1'b0;
        rd_rsp_ready_i    = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        idle_after_reset();
        read_miss();
        write_miss();
        invalidation();
        back_pressure();
        @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

/* verilog/l2_channels.sv */
`timescale 1ns/1ps

module l2_channels (
    input  logic                           clk,
    input  logic                           rst,
    // cpu_req
    input  logic                           cpu_req_valid_i,
    output logic                           cpu_req_ready_o,
    input  l2_pkg::cpu_msg_t               cpu_req_cpu_msg_i,
    input  logic [l2_pkg::HSIZE_BITS-1:0]  cpu_req_hsize_i,
    input  logic [l2_pkg::HPROT_BITS-1:0]  cpu_req_hprot_i,
    input  logic [l2_pkg::ADDR_BITS-1:0]   cpu_req_addr_i,
    input  logic [l2_pkg::WORD_BITS-1:0]   cpu_req_word_i,
    // fwd_in
    input  logic                           fwd_in_valid_i,
    output logic                           fwd_in_ready_o,
    input  l2_pkg::coh_msg_t               fwd_in_coh_msg_i,
    input  logic [l2_pkg::ADDR_BITS-1:0]   fwd_in_addr_i,
    input  logic [l2_pkg::REQ_ID_BITS-1:0] fwd_in_req_id_i,
    // rsp_in
    input  logic                           rsp_in_valid_i,
    output logic                           rsp_in_ready_o,
    input  l2_pkg::coh_msg_t               rsp_in_coh_msg_i,
    input  logic [l2_pkg::ADDR_BITS-1:0]   rsp_in_addr_i,
    input  logic [l2_pkg::LINE_BITS-1:0]   rsp_in_line_i,
    // req_out
    output logic                           req_out_valid_o,
    input  logic                           req_out_ready_i,
    output l2_pkg::coh_msg_t               req_out_coh_msg_o,
    output logic [l2_pkg::HPROT_BITS-1:0]  req_out_hprot_o,
    output logic [l2_pkg::ADDR_BITS-1:0]   req_out_addr_o,
    output logic [l2_pkg::LINE_BITS-1:0]   req_out_line_o,
    // rsp_out
    output logic                           rsp_out_valid_o,
    input  logic                           rsp_out_ready_i,
    output l2_pkg::coh_msg_t               rsp_out_coh_msg_o,
    output logic [l2_pkg::REQ_ID_BITS-1:0] rsp_out_req_id_o,
    output logic                           rsp_out_to_req_o,
    output logic [l2_pkg::ADDR_BITS-1:0]   rsp_out_addr_o,
    output logic [l2_pkg::LINE_BITS-1:0]   rsp_out_line_o,
    // rd_rsp
    output logic                           rd_rsp_valid_o,
    input  logic                           rd_rsp_ready_i,
    output logic [l2_pkg::LINE_BITS-1:0]   rd_rsp_line_o
);

    import l2_pkg::*;

    logic                    cpu_valid;
    logic                    cpu_ready;
    logic [CPU_REQ_BITS-1:0] cpu_data;
    logic                    fwd_valid;
    logic                    fwd_ready;
    logic [FWD_IN_BITS-1:0]  fwd_data;
    logic                    rsp_valid;
    logic                    rsp_ready;
    logic [RSP_IN_BITS-1:0]  rsp_data;
    logic                    req_valid;
    logic                    req_ready;
    coh_msg_t                req_msg;
    logic [HPROT_BITS-1:0]   req_hprot;
    logic [ADDR_BITS-1:0]    req_addr;
    logic [LINE_BITS-1:0]    req_line;
    logic [REQ_OUT_BITS-1:0] req_data;
    logic                    rso_valid;
    logic                    rso_ready;
    coh_msg_t                rso_msg;
    logic [REQ_ID_BITS-1:0]  rso_req_id;
    logic                    rso_to_req;
    logic [ADDR_BITS-1:0]    rso_addr;
    logic [LINE_BITS-1:0]    rso_line;
    logic [RSP_OUT_BITS-1:0] rso_data;
    logic                    rd_valid;
    logic                    rd_ready;
    logic [RD_RSP_BITS-1:0]  rd_line;

    // Input side
    l2_skid_buffer #(.WIDTH(CPU_REQ_BITS)) i_cpu_req_buf (
        .clk(clk), .rst(rst),
        .valid_i(cpu_req_valid_i), .ready_o(cpu_req_ready_o),
        .data_i({cpu_req_cpu_msg_i, cpu_req_hsize_i, cpu_req_hprot_i,
                 cpu_req_addr_i, cpu_req_word_i}),
        .valid_o(cpu_valid), .ready_i(cpu_ready), .data_o(cpu_data)
    );

    l2_skid_buffer #(.WIDTH(FWD_IN_BITS)) i_fwd_in_buf (
        .clk(clk), .rst(rst),
        .valid_i(fwd_in_valid_i), .ready_o(fwd_in_ready_o),
        .data_i({fwd_in_coh_msg_i, fwd_in_addr_i, fwd_in_req_id_i}),
        .valid_o(fwd_valid), .ready_i(fwd_ready), .data_o(fwd_data)
    );

    l2_skid_buffer #(.WIDTH(RSP_IN_BITS)) i_rsp_in_buf (
        .clk(clk), .rst(rst),
        .valid_i(rsp_in_valid_i), .ready_o(rsp_in_ready_o),
        .data_i({rsp_in_coh_msg_i, rsp_in_addr_i, rsp_in_line_i}),
        .valid_o(rsp_valid), .ready_i(rsp_ready), .data_o(rsp_data)
    );

    // hsize rides along in cpu_data but the controller has no use for it
    l2_coh_ctrl i_coh_ctrl (
        .clk(clk), .rst(rst),
        .cpu_valid_i(cpu_valid), .cpu_ready_o(cpu_ready),
        .cpu_msg_i(cpu_msg_t'(cpu_data[CPU_REQ_BITS-1 -: CPU_MSG_BITS])),
        .cpu_hprot_i(cpu_data[WORD_BITS+ADDR_BITS +: HPROT_BITS]),
        .cpu_addr_i(cpu_data[WORD_BITS +: ADDR_BITS]),
        .cpu_word_i(cpu_data[WORD_BITS-1:0]),
        .fwd_valid_i(fwd_valid), .fwd_ready_o(fwd_ready),
        .fwd_msg_i(coh_msg_t'(fwd_data[FWD_IN_BITS-1 -: COH_MSG_BITS])),
        .fwd_addr_i(fwd_data[REQ_ID_BITS +: ADDR_BITS]),
        .fwd_req_id_i(fwd_data[REQ_ID_BITS-1:0]),
        .rsp_valid_i(rsp_valid), .rsp_ready_o(rsp_ready),
        .rsp_msg_i(coh_msg_t'(rsp_data[RSP_IN_BITS-1 -: COH_MSG_BITS])),
        .rsp_line_i(rsp_data[LINE_BITS-1:0]),
        .req_valid_o(req_valid), .req_ready_i(req_ready), .req_msg_o(req_msg),
        .req_hprot_o(req_hprot), .req_addr_o(req_addr), .req_line_o(req_line),
        .rsp_out_valid_o(rso_valid), .rsp_out_ready_i(rso_ready), .rsp_out_msg_o(rso_msg),
        .rsp_out_req_id_o(rso_req_id), .rsp_out_to_req_o(rso_to_req),
        .rsp_out_addr_o(rso_addr), .rsp_out_line_o(rso_line),
        .rd_valid_o(rd_valid), .rd_ready_i(rd_ready), .rd_line_o(rd_line)
    );

    // Output side
    l2_skid_buffer #(.WIDTH(REQ_OUT_BITS)) i_req_out_buf (
        .clk(clk), .rst(rst),
        .valid_i(req_valid), .ready_o(req_ready),
        .data_i({req_msg, req_hprot, req_addr, req_line}),
        .valid_o(req_out_valid_o), .ready_i(req_out_ready_i), .data_o(req_data)
    );

    l2_skid_buffer #(.WIDTH(RSP_OUT_BITS)) i_rsp_out_buf (
        .clk(clk), .rst(rst),
        .valid_i(rso_valid), .ready_o(rso_ready),
        .data_i({rso_msg, rso_req_id, rso_to_req, rso_addr, rso_line}),
        .valid_o(rsp_out_valid_o), .ready_i(rsp_out_ready_i), .data_o(rso_data)
    );

    l2_skid_buffer #(.WIDTH(RD_RSP_BITS)) i_rd_rsp_buf (
        .clk(clk), .rst(rst),
        .valid_i(rd_valid), .ready_o(rd_ready), .data_i(rd_line),
        .valid_o(rd_rsp_valid_o), .ready_i(rd_rsp_ready_i), .data_o(rd_rsp_line_o)
    );

    assign req_out_coh_msg_o = coh_msg_t'(req_data[REQ_OUT_BITS-1 -: COH_MSG_BITS]);
    assign req_out_hprot_o   = req_data[LINE_BITS+ADDR_BITS +: HPROT_BITS];
    assign req_out_addr_o    = req_data[LINE_BITS +: ADDR_BITS];
    assign req_out_line_o    = req_data[LINE_BITS-1:0];

    assign rsp_out_coh_msg_o = coh_msg_t'(rso_data[RSP_OUT_BITS-1 -: COH_MSG_BITS]);
    assign rsp_out_req_id_o  = rso_data[LINE_BITS+ADDR_BITS+1 +: REQ_ID_BITS];
    assign rsp_out_to_req_o  = rso_data[LINE_BITS+ADDR_BITS];
    assign rsp_out_addr_o    = rso_data[LINE_BITS +: ADDR_BITS];
    assign rsp_out_line_o    = rso_data[LINE_BITS-1:0];

endmodule

/* verilog/l2_coh_ctrl.sv */
`timescale 1ns/1ps

module l2_coh_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    // CPU request
    input  logic                           cpu_valid_i,
    output logic                           cpu_ready_o,
    input  l2_pkg::cpu_msg_t               cpu_msg_i,
    input  logic [l2_pkg::HPROT_BITS-1:0]  cpu_hprot_i,
    input  logic [l2_pkg::ADDR_BITS-1:0]   cpu_addr_i,
    input  logic [l2_pkg::WORD_BITS-1:0]   cpu_word_i,
    // Forwarded messages
    input  logic                           fwd_valid_i,
    output logic                           fwd_ready_o,
    input  l2_pkg::coh_msg_t               fwd_msg_i,
    input  logic [l2_pkg::ADDR_BITS-1:0]   fwd_addr_i,
    input  logic [l2_pkg::REQ_ID_BITS-1:0] fwd_req_id_i,
    // Responses in
    input  logic                           rsp_valid_i,
    output logic                           rsp_ready_o,
    input  l2_pkg::coh_msg_t               rsp_msg_i,
    input  logic [l2_pkg::LINE_BITS-1:0]   rsp_line_i,
    // Requests out
    output logic                           req_valid_o,
    input  logic                           req_ready_i,
    output l2_pkg::coh_msg_t               req_msg_o,
    output logic [l2_pkg::HPROT_BITS-1:0]  req_hprot_o,
    output logic [l2_pkg::ADDR_BITS-1:0]   req_addr_o,
    output logic [l2_pkg::LINE_BITS-1:0]   req_line_o,
    // Responses out
    output logic                           rsp_out_valid_o,
    input  logic                           rsp_out_ready_i,
    output l2_pkg::coh_msg_t               rsp_out_msg_o,
    output logic [l2_pkg::REQ_ID_BITS-1:0] rsp_out_req_id_o,
    output logic                           rsp_out_to_req_o,
    output logic [l2_pkg::ADDR_BITS-1:0]   rsp_out_addr_o,
    output logic [l2_pkg::LINE_BITS-1:0]   rsp_out_line_o,
    // Read data to CPU
    output logic                           rd_valid_o,
    input  logic                           rd_ready_i,
    output logic [l2_pkg::LINE_BITS-1:0]   rd_line_o
);

    import l2_pkg::*;

    ctrl_state_t                       state_q;
    ctrl_state_t                       state_d;
    cpu_msg_t                          msg_q;
    logic [HPROT_BITS-1:0]             hprot_q;
    logic [ADDR_BITS-1:0]              addr_q;
    logic [WORD_BITS-1:0]              word_q;
    logic [LINE_BITS-1:0]              line_q;
    logic [LINE_BITS-1:0]              merged_line;
    logic [$clog2(WORDS_PER_LINE)-1:0] word_sel;
    logic [ADDR_BITS-1:0]              line_addr;
    logic                              cpu_fire;
    logic                              rsp_fire;
    logic                              fwd_fire;
    logic                              inv_pending_q;
    logic [REQ_ID_BITS-1:0]            inv_req_id_q;
    logic [ADDR_BITS-1:0]              inv_addr_q;

    assign cpu_ready_o = (state_q == ST_IDLE);
    assign rsp_ready_o = (state_q == ST_WAIT_DATA);
    assign cpu_fire    = cpu_valid_i && cpu_ready_o;
    assign rsp_fire    = rsp_valid_i && rsp_ready_o;

    assign word_sel  = addr_q[LINE_LSB-1:OFFSET_LSB];
    assign line_addr = {addr_q[ADDR_BITS-1:LINE_LSB], {LINE_LSB{1'b0}}};

    // Write word goes into its slot of the fetched line
    always_comb begin
        merged_line = rsp_line_i;
        merged_line[word_sel*WORD_BITS +: WORD_BITS] = word_q;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cpu_fire) state_d = ST_SEND_REQ;
            end
            ST_SEND_REQ: begin
                if (req_ready_i) state_d = ST_WAIT_DATA;
            end
            ST_WAIT_DATA: begin
                if (rsp_fire) state_d = (msg_q == CPU_WRITE) ? ST_SEND_PUTM : ST_SEND_RD;
            end
            ST_SEND_RD: begin
                if (rd_ready_i) state_d = ST_IDLE;
            end
            ST_SEND_PUTM: begin
                if (req_ready_i) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_fire) begin
            msg_q   <= cpu_msg_i;
            hprot_q <= cpu_hprot_i;
            addr_q  <= cpu_addr_i;
            word_q  <= cpu_word_i;
        end
        if (rsp_fire) begin
            line_q <= (msg_q == CPU_WRITE) ? merged_line : rsp_line_i;
        end
    end

    assign req_valid_o = (state_q == ST_SEND_REQ) || (state_q == ST_SEND_PUTM);
    assign req_msg_o   = (state_q == ST_SEND_PUTM) ? REQ_PUTM :
                         (msg_q == CPU_WRITE)      ? REQ_GETM : REQ_GETS;
    assign req_hprot_o = hprot_q;
    assign req_addr_o  = line_addr;
    assign req_line_o  = (state_q == ST_SEND_PUTM) ? line_q : '0;

    assign rd_valid_o = (state_q == ST_SEND_RD);
    assign rd_line_o  = line_q;

    // Invalidation path, independent of the miss FSM
    assign fwd_ready_o = !inv_pending_q;
    assign fwd_fire    = fwd_valid_i && fwd_ready_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            inv_pending_q <= 1'b0;
        end else if (fwd_fire) begin
            inv_pending_q <= 1'b1;
        end else if (rsp_out_ready_i) begin
            inv_pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_fire) begin
            inv_req_id_q <= fwd_req_id_i;
            inv_addr_q   <= fwd_addr_i;
        end
    end

    assign rsp_out_valid_o  = inv_pending_q;
    assign rsp_out_msg_o    = RSP_INVACK;
    assign rsp_out_req_id_o = inv_req_id_q;
    assign rsp_out_to_req_o = 1'b1;
    assign rsp_out_addr_o   = inv_addr_q;
    assign rsp_out_line_o   = '0;

    a_rsp_is_data: assert property (
        @(posedge clk) disable iff (!rst)
        rsp_valid_i |-> rsp_msg_i == RSP_DATA
    );

    a_fwd_is_inv: assert property (
        @(posedge clk) disable iff (!rst)
        fwd_valid_i |-> fwd_msg_i == FWD_INV
    );

    // Data only shows up for an outstanding miss
    a_rsp_only_in_wait: assert property (
        @(posedge clk) disable iff (!rst)
        rsp_valid_i |-> state_q == ST_WAIT_DATA
    );

endmodule

/* verilog/l2_pkg.sv */
package l2_pkg;

    localparam int ADDR_BITS      = 32;
    localparam int LINE_BITS      = 128;
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_LSB     = 2;
    localparam int LINE_LSB       = 4;
    localparam int REQ_ID_BITS    = 4;
    localparam int HPROT_BITS     = 2;
    localparam int HSIZE_BITS     = 3;
    localparam int CPU_MSG_BITS   = 1;
    localparam int COH_MSG_BITS   = 3;

    typedef enum logic [CPU_MSG_BITS-1:0] {
        CPU_READ  = 1'b0,
        CPU_WRITE = 1'b1
    } cpu_msg_t;

    typedef enum logic [COH_MSG_BITS-1:0] {
        REQ_GETS   = 3'd0,
        REQ_GETM   = 3'd1,
        REQ_PUTM   = 3'd2,
        RSP_DATA   = 3'd3,
        RSP_INVACK = 3'd4,
        FWD_INV    = 3'd5
    } coh_msg_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND_REQ,
        ST_WAIT_DATA,
        ST_SEND_RD,
        ST_SEND_PUTM
    } ctrl_state_t;

    // Payload widths through the skid buffers
    localparam int CPU_REQ_BITS = CPU_MSG_BITS + HSIZE_BITS + HPROT_BITS + ADDR_BITS + WORD_BITS;
    localparam int FWD_IN_BITS  = COH_MSG_BITS + ADDR_BITS + REQ_ID_BITS;
    localparam int RSP_IN_BITS  = COH_MSG_BITS + ADDR_BITS + LINE_BITS;
    localparam int REQ_OUT_BITS = COH_MSG_BITS + HPROT_BITS + ADDR_BITS + LINE_BITS;
    localparam int RSP_OUT_BITS = COH_MSG_BITS + REQ_ID_BITS + 1 + ADDR_BITS + LINE_BITS;
    localparam int RD_RSP_BITS  = LINE_BITS;

endpackage

/* verilog/l2_skid_buffer.sv */
`timescale 1ns/1ps

module l2_skid_buffer #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_i,
    output logic             ready_o,
    input  logic [WIDTH-1:0] data_i,
    output logic             valid_o,
    input  logic             ready_i,
    output logic [WIDTH-1:0] data_o
);

    logic             full_q;
    logic [WIDTH-1:0] hold_q;
    logic             capture;

    // Only take the item when it cannot pass straight through
    assign capture = valid_i && !full_q && !ready_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full_q <= 1'b0;
        end else if (capture) begin
            full_q <= 1'b1;
        end else if (ready_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            hold_q <= data_i;
        end
    end

    assign ready_o = !full_q;
    assign valid_o = full_q || valid_i;
    // Bypass while empty
    assign data_o  = full_q ? hold_q : data_i;

    // Item refused while full stays offered until the buffer drains
    a_no_capture_when_full: assert property (
        @(posedge clk) disable iff (!rst)
        valid_i && full_q |=> valid_i && $stable(data_i)
    );

    // Stalled output keeps its item, whether bypassed or held
    a_data_stable_on_stall: assert property (
        @(posedge clk) disable iff (!rst)
        valid_o && !ready_i |=> valid_o && $stable(data_o)
    );

endmodule
